//--- design/fpCvtPkg.sv
// ==============================
// Shared binary128 field widths, bias, operand and class types
// Every conversion block refers to these by scoped name
// ==============================

package fpCvtPkg;

	// ==============================
	// Format constants
	// ==============================

	// Biased exponent field width of the quad precision format
	localparam int expBits = 15;

	// Stored fraction width, the hidden one is not counted
	localparam int fracBits = 112;

	// Exponent bias, the biased value of an operand in [1, 2)
	localparam int expBias = 16383;

	// Width of the integer result and of the packed float word
	localparam int intBits = 128;

	// ==============================
	// Vector types
	// ==============================

	// Biased exponent as stored in the operand
	typedef logic [expBits-1:0] fpExpT;

	// Stored fraction without the hidden bit
	typedef logic [fracBits-1:0] fpFracT;

	// Result word, carries either a packed float or a signed integer
	typedef logic [intBits-1:0] word128T;

	// Unbiased exponent, wide enough for every biased value minus the bias
	typedef logic signed [15:0] unbExpT;

	// Operation code of the conversion unit
	typedef logic [0:0] cvtOpT;

	// Truncate and keep floating-point form
	localparam cvtOpT opTrunc = 1'b0;

	// Convert to a signed integer, rounded toward zero
	localparam cvtOpT opToInt = 1'b1;

	// ==============================
	// Structured types
	// ==============================

	// Operand layout, sign in the top bit, then exponent, then fraction
	typedef struct packed {
		logic sign;
		fpExpT exp;
		fpFracT sig;
	} fp128T;

	// Class flags, isFrac marks a magnitude below one
	typedef struct packed {
		logic isZero;
		logic isSub;
		logic isInf;
		logic isNan;
		logic isFrac;
	} fpClassT;

endpackage

//--- design/fpClassify.sv
// ==============================
// Binary128 operand decoder into class flags and unbiased exponent
// Combinational, its outputs feed both conversion units
// ==============================
`timescale 1ns/1ps

module fpClassify (
	input fpCvtPkg::fp128T a,
	output fpCvtPkg::fpClassT cls,
	output fpCvtPkg::unbExpT unbExp
);

	// Exponent field patterns that mark the special encodings
	logic expAllZero;
	logic expAllOnes;

	// Stored fraction is all zero, splits zero from subnormal and inf from NaN
	logic fracZero;

	assign expAllZero = (a.exp == '0);
	assign expAllOnes = &a.exp;
	assign fracZero = (a.sig == '0);

	always_comb begin
		// An all zero exponent holds zero or a subnormal
		cls.isZero = expAllZero & fracZero;
		cls.isSub = expAllZero & ~fracZero;

		// An all ones exponent holds infinity or NaN
		cls.isInf = expAllOnes & fracZero;
		cls.isNan = expAllOnes & ~fracZero;

		// Below the bias the magnitude is under one
		// Zeros and subnormals fall in this range as well
		cls.isFrac = (a.exp < fpCvtPkg::fpExpT'(fpCvtPkg::expBias));
	end

	// Zero extend the biased exponent before removing the bias
	// The 16 bit signed range covers -16383 up to 16384
	always_comb begin
		unbExp = fpCvtPkg::unbExpT'({1'b0, a.exp})
			- fpCvtPkg::unbExpT'(fpCvtPkg::expBias);
	end

endmodule

//--- design/fpTrunc.sv
// ==============================
// Truncation toward zero that keeps the floating-point form
// One cycle of latency, loads under ce
// ==============================
`timescale 1ns/1ps

module fpTrunc (
	input logic clk,
	input logic rstN,
	input logic ce,
	input fpCvtPkg::fp128T a,
	input fpCvtPkg::fpClassT cls,
	input fpCvtPkg::unbExpT unbExp,
	output fpCvtPkg::fp128T res
);

	// ==============================
	// Fraction mask
	// ==============================

	// Shift amount for the mask, only meaningful for an exponent of 0 to 111
	logic [6:0] shAmt;

	// Ones at every stored fraction bit at or above the binary point
	fpCvtPkg::fpFracT mask;

	// Operand fraction with the bits below the binary point cleared
	fpCvtPkg::fpFracT fracKeep;

	// Operand already integral or special, it passes through untouched
	logic passThru;

	// Value loaded into the output register on an enabled edge
	fpCvtPkg::fp128T nextRes;

	assign shAmt = unbExp[6:0];

	// An exponent of e leaves e fraction bits above the binary point
	// Shifting an all ones word right by e and inverting keeps the top e bits
	always_comb begin
		mask = ~({fpCvtPkg::fracBits{1'b1}} >> shAmt);
	end

	assign fracKeep = a.sig & mask;

	// Once e reaches the fraction width, no stored bit lies below the point
	// Infinity and NaN have the largest exponent and are listed for clarity
	assign passThru = cls.isInf | cls.isNan
		| (unbExp >= fpCvtPkg::unbExpT'(fpCvtPkg::fracBits));

	// ==============================
	// Result selection and register
	// ==============================

	always_comb begin
		if (cls.isFrac) begin
			// Anything under one truncates to positive zero
			nextRes = '0;
		end else if (passThru) begin
			nextRes = a;
		end else begin
			// Sign and exponent are kept, the fraction loses its low bits
			nextRes.sign = a.sign;
			nextRes.exp = a.exp;
			nextRes.sig = fracKeep;
		end
	end

	// Output register holds its value while ce is low
	always_ff @(posedge clk) begin
		if (!rstN) begin
			res <= '0;
		end else if (ce) begin
			res <= nextRes;
		end
	end

endmodule

//--- design/fpToInt.sv
// ==============================
// Binary128 to signed 128-bit integer, rounded toward zero, saturating
// One cycle of latency, result and overflow load under ce
// ==============================
`timescale 1ns/1ps

module fpToInt (
	input logic clk,
	input logic rstN,
	input logic ce,
	input fpCvtPkg::fp128T a,
	input fpCvtPkg::fpClassT cls,
	input fpCvtPkg::unbExpT unbExp,
	output fpCvtPkg::word128T res,
	output logic overflow
);

	// Hidden bit, set only for normal operands
	logic hidden;

	// Significand with the hidden bit on top, placed in a full result word
	fpCvtPkg::word128T wideSig;

	// Shift distances relative to the binary point at bit 112
	fpCvtPkg::unbExpT leftAmt;
	fpCvtPkg::unbExpT rightAmt;

	// Integer magnitude and its signed form
	fpCvtPkg::word128T mag;
	fpCvtPkg::word128T intVal;

	// Exactly minus two to the 127, the one value at e = 127 that fits
	logic isMinLimit;

	// Overflow condition and the saturated value for it
	logic ovf;
	fpCvtPkg::word128T satVal;

	// Value loaded into the result register on an enabled edge
	fpCvtPkg::word128T nextRes;

	// ==============================
	// Magnitude
	// ==============================

	assign hidden = ~(cls.isZero | cls.isSub);
	assign wideSig = fpCvtPkg::word128T'({hidden, a.sig});

	assign leftAmt = unbExp - fpCvtPkg::unbExpT'(fpCvtPkg::fracBits);
	assign rightAmt = fpCvtPkg::unbExpT'(fpCvtPkg::fracBits) - unbExp;

	// From e = 112 up the point lies below the significand, shift it up
	// The largest shift of 15 at e = 127 still fits the 128-bit word
	// Below e = 112 the right shift drops the fraction, which rounds toward zero
	always_comb begin
		if (unbExp >= fpCvtPkg::unbExpT'(fpCvtPkg::fracBits)) begin
			mag = wideSig << leftAmt[3:0];
		end else begin
			mag = wideSig >> rightAmt[6:0];
		end
	end

	// Two's complement negation, 2**127 maps onto the most negative value
	assign intVal = a.sign ? (~mag + 1'b1) : mag;

	// ==============================
	// Overflow and saturation
	// ==============================

	assign isMinLimit = a.sign & (unbExp == fpCvtPkg::unbExpT'(fpCvtPkg::intBits - 1))
		& (a.sig == '0);

	assign ovf = cls.isNan | cls.isInf
		| ((unbExp >= fpCvtPkg::unbExpT'(fpCvtPkg::intBits - 1)) & ~isMinLimit);

	// NaN goes to the positive limit whatever its sign bit says
	always_comb begin
		if (a.sign & ~cls.isNan) begin
			satVal = {1'b1, {(fpCvtPkg::intBits - 1){1'b0}}};
		end else begin
			satVal = {1'b0, {(fpCvtPkg::intBits - 1){1'b1}}};
		end
	end

	always_comb begin
		if (ovf) begin
			nextRes = satVal;
		end else if (cls.isFrac) begin
			// Zeros, subnormals and anything under one give zero
			nextRes = '0;
		end else begin
			nextRes = intVal;
		end
	end

	// Registers hold while ce is low
	always_ff @(posedge clk) begin
		if (!rstN) begin
			res <= '0;
			overflow <= 1'b0;
		end else if (ce) begin
			res <= nextRes;
			overflow <= ovf;
		end
	end

endmodule

//--- design/fpCvtUnit.sv
// ==============================
// Conversion unit top, truncation or float to integer per operand
// Drive ce, op and a on a clock edge, result follows one cycle later
// ==============================
`timescale 1ns/1ps

module fpCvtUnit (
	input logic clk,
	input logic rstN,
	input logic ce,
	input fpCvtPkg::cvtOpT op,
	input fpCvtPkg::fp128T a,
	output fpCvtPkg::word128T result,
	output logic overflow
);

	// Class flags and unbiased exponent, shared by both units
	fpCvtPkg::fpClassT cls;
	fpCvtPkg::unbExpT unbExp;

	// Registered results of the two units
	fpCvtPkg::fp128T truncRes;
	fpCvtPkg::word128T intRes;
	logic intOvf;

	// Operation code that travels alongside its operand
	fpCvtPkg::cvtOpT opQ;

	// ==============================
	// Shared decode and units
	// ==============================

	fpClassify fpClassify_inst (
		.a(a),
		.cls(cls),
		.unbExp(unbExp)
	);

	// Both units run on every enabled operand, opQ picks the one to show
	fpTrunc fpTrunc_inst (
		.clk(clk),
		.rstN(rstN),
		.ce(ce),
		.a(a),
		.cls(cls),
		.unbExp(unbExp),
		.res(truncRes)
	);

	fpToInt fpToInt_inst (
		.clk(clk),
		.rstN(rstN),
		.ce(ce),
		.a(a),
		.cls(cls),
		.unbExp(unbExp),
		.res(intRes),
		.overflow(intOvf)
	);

	// ==============================
	// Output selection
	// ==============================

	// Same enable and latency as the unit registers, so the code stays aligned
	always_ff @(posedge clk) begin
		if (!rstN) begin
			opQ <= fpCvtPkg::opTrunc;
		end else if (ce) begin
			opQ <= op;
		end
	end

	// After reset opQ selects the cleared truncation register, result reads zero
	assign result = (opQ == fpCvtPkg::opTrunc) ? fpCvtPkg::word128T'(truncRes) : intRes;

	// Truncation never overflows
	assign overflow = (opQ == fpCvtPkg::opToInt) & intOvf;

endmodule

//--- tests/fpCvtChecker.sv
// ==============================
// Checker that models truncation and integer conversion from the format rules
// Compares the DUT outputs on each falling edge and reports per test and in total
// ==============================
`timescale 1ns/1ps

module fpCvtChecker (
	input logic clk,
	input logic rstN,
	input logic ce,
	input fpCvtPkg::cvtOpT op,
	input fpCvtPkg::fp128T a,
	input fpCvtPkg::word128T result,
	input logic overflow,
	input logic [2:0] testIdx,
	input logic testEnd,
	input logic allDone,
	output logic busy,
	output logic reportDone,
	output int errTotal
);

	// Expected outputs are reloaded on every enabled edge and held otherwise
	fpCvtPkg::word128T expRes = '0;
	logic expOvf = 1'b0;

	// Captures and compares so far differ while a result is still due
	int capCount = 0;
	int cmpCount = 0;

	// Running totals with snapshots taken at the start of each test
	int checks = 0;
	int failCount = 0;
	int checkBase = 0;
	int errBase = 0;
	logic [2:0] curTest = '0;
	logic closed = 1'b0;

	// Rises on the first rising edge out of reset and gates the comparisons
	logic live = 1'b0;

	assign busy = (capCount != cmpCount);
	assign reportDone = closed;
	assign errTotal = failCount;

	function automatic string testName(input logic [2:0] idx);
		case (idx)
			3'd0: return "reset";
			3'd1: return "truncation";
			3'd2: return "conversion in range";
			3'd3: return "saturation";
			default: return "enable and mixing";
		endcase
	endfunction

	// Truncation rebuilt by shifting the integer part down and back up
	function automatic fpCvtPkg::word128T modelTrunc(input fpCvtPkg::fp128T v);
		int e;
		logic [112:0] whole;
		e = int'(v.exp) - fpCvtPkg::expBias;
		// Under one gives positive zero while integral and special values pass
		if (e < 0) return '0;
		if (e >= 112) return v;
		whole = {1'b1, v.sig} >> (112 - e);
		whole = whole << (112 - e);
		return {v.sign, v.exp, whole[111:0]};
	endfunction

	// Integer value sits in the low 128 bits with the overflow flag on top
	function automatic logic [128:0] modelInt(input fpCvtPkg::fp128T v);
		int e;
		logic [255:0] mag;
		logic [127:0] maxPos;
		maxPos = {1'b0, {127{1'b1}}};
		e = int'(v.exp) - fpCvtPkg::expBias;
		if (v.exp == {fpCvtPkg::expBits{1'b1}} && v.sig != '0) return {1'b1, maxPos};
		// Infinity lands here too since only -2**127 fits at e = 127
		if (e >= 127 && !(v.sign && e == 127 && v.sig == '0)) begin
			return {1'b1, v.sign ? ~maxPos : maxPos};
		end
		if (e < 0) return '0;
		mag = {143'b0, 1'b1, v.sig};
		mag = (e >= 112) ? (mag << (e - 112)) : (mag >> (112 - e));
		return {1'b0, v.sign ? -mag[127:0] : mag[127:0]};
	endfunction

	// ==============================
	// Capture and reporting
	// ==============================

	always @(posedge clk) begin
		logic [128:0] m;
		curTest <= testIdx;
		live <= rstN;
		if (!rstN) begin
			expRes <= '0;
			expOvf <= 1'b0;
		end else if (ce) begin
			m = modelInt(a);
			expRes <= (op == fpCvtPkg::opTrunc) ? modelTrunc(a) : m[127:0];
			// Overflow only shows for a conversion
			expOvf <= (op == fpCvtPkg::opToInt) & m[128];
			capCount <= capCount + 1;
		end
		if (testEnd) begin
			$display("Test %s: %0d checks, %0d errors", testName(testIdx),
				checks - checkBase, failCount - errBase);
			checkBase <= checks;
			errBase <= failCount;
		end
		if (allDone && !closed) begin
			$display("Totals: %0d checks, %0d errors", checks, failCount);
			closed <= 1'b1;
		end
	end

	// Outputs settled half a cycle ago and held values are checked as well
	always @(negedge clk) begin
		if (live) begin
			checks <= checks + 1;
			if (result !== expRes || overflow !== expOvf) failCount <= failCount + 1;
			if (result !== expRes) begin
				$display("** Error [%s] result expected %h actual %h",
					testName(curTest), expRes, result);
			end
			if (overflow !== expOvf) begin
				$display("** Error [%s] overflow expected %0b actual %0b",
					testName(curTest), expOvf, overflow);
			end
		end
		cmpCount <= capCount;
	end

endmodule

//--- tests/fpCvtTb.sv
// ==============================
// Testbench top that drives seeded random operands through the conversion unit
// Five tests run in order while fpCvtChecker does the comparing
// ==============================
`timescale 1ns/1ps

module fpCvtTb;

	logic clk = 1'b0;
	logic rstN;
	logic ce;
	fpCvtPkg::cvtOpT op;
	fpCvtPkg::fp128T a;
	fpCvtPkg::word128T result;
	logic overflow;

	// Test sequencing shared with the checker
	logic [2:0] testIdx;
	logic testEnd;
	logic allDone;
	logic busy;
	logic reportDone;
	int errTotal;
	int seed;

	// Set once a test never saw its last result, the remaining tests are skipped
	logic stalled;

	always #50 clk = ~clk;

	fpCvtUnit fpCvtUnit_inst (
		.clk(clk),
		.rstN(rstN),
		.ce(ce),
		.op(op),
		.a(a),
		.result(result),
		.overflow(overflow)
	);

	fpCvtChecker fpCvtChecker_inst (
		.clk(clk),
		.rstN(rstN),
		.ce(ce),
		.op(op),
		.a(a),
		.result(result),
		.overflow(overflow),
		.testIdx(testIdx),
		.testEnd(testEnd),
		.allDone(allDone),
		.busy(busy),
		.reportDone(reportDone),
		.errTotal(errTotal)
	);

	// Random sign and fraction with the biased exponent drawn from [expLo, expLo + span)
	task automatic randomOperand(input int expLo, input int span,
		output fpCvtPkg::fp128T v);
		logic [127:0] bits;
		bits = {$random(seed), $random(seed), $random(seed), $random(seed)};
		v.sign = bits[127];
		v.exp = fpCvtPkg::fpExpT'(expLo + int'($unsigned($random(seed)) % span));
		v.sig = bits[111:0];
	endtask

	// Kinds 0 and 1 are zeros, 2 a subnormal, 3 and 4 infinities, 5 a NaN, 6 minus 2**127
	task automatic specialOperand(input int kind, output fpCvtPkg::fp128T v);
		logic [127:0] bits;
		bits = {$random(seed), $random(seed), $random(seed), $random(seed)};
		v.sign = (kind == 1 || kind == 4 || kind == 6) ? 1'b1 : bits[127];
		v.exp = (kind >= 3 && kind <= 5) ? {fpCvtPkg::expBits{1'b1}} : '0;
		v.sig = (kind == 2 || kind == 5) ? (bits[111:0] | 112'd1) : '0;
		if (kind == 6) v.exp = fpCvtPkg::fpExpT'(fpCvtPkg::expBias + 127);
	endtask

	// Drive one cycle of inputs from a falling edge to the next
	task automatic applyOperand(input logic en, input fpCvtPkg::cvtOpT o,
		input fpCvtPkg::fp128T v);
		ce = en;
		op = o;
		a = v;
		@(negedge clk);
	endtask

	// Let the last result be compared and then have the checker report the test
	task automatic closeTest();
		int waited;
		ce = 1'b0;
		waited = 0;
		@(posedge clk);
		while (busy && waited < 20) begin
			@(posedge clk);
			waited++;
		end
		if (busy) begin
			$display("Timeout: test %0d never received its last result", testIdx);
			stalled = 1'b1;
		end else begin
			@(negedge clk);
			testEnd = 1'b1;
			@(negedge clk);
			testEnd = 1'b0;
			testIdx = testIdx + 1'b1;
		end
	endtask

	initial begin
		fpCvtPkg::fp128T v;
		int i;
		int k;
		seed = 32'h45a5;
		stalled = 1'b0;
		rstN = 1'b0;
		ce = 1'b0;
		op = fpCvtPkg::opTrunc;
		a = '0;
		testIdx = '0;
		testEnd = 1'b0;
		allDone = 1'b0;
		repeat (8) @(negedge clk);
		rstN = 1'b1;
		// Outputs stay at zero while nothing is enabled
		repeat (3) @(negedge clk);
		closeTest();
		// Truncation over the window from under one to past 2**130
		for (i = 0; i < 48 && !stalled; i++) begin
			if (i % 6 == 0) specialOperand(int'($unsigned($random(seed)) % 7), v);
			else randomOperand(fpCvtPkg::expBias - 4, 135, v);
			applyOperand(1'b1, fpCvtPkg::opTrunc, v);
		end
		if (!stalled) closeTest();
		// Conversion below 2**127 with zeros and subnormals mixed in
		for (i = 0; i < 40 && !stalled; i++) begin
			if (i % 8 == 0) specialOperand(int'($unsigned($random(seed)) % 3), v);
			else randomOperand(fpCvtPkg::expBias - 4, 131, v);
			applyOperand(1'b1, fpCvtPkg::opToInt, v);
		end
		if (!stalled) closeTest();
		// Saturation range, infinities, NaN and the exact negative limit
		for (i = 0; i < 32 && !stalled; i++) begin
			if (i % 4 == 0) specialOperand(3 + int'($unsigned($random(seed)) % 4), v);
			else randomOperand(fpCvtPkg::expBias + 127, 4, v);
			applyOperand(1'b1, fpCvtPkg::opToInt, v);
		end
		if (!stalled) closeTest();
		// Alternating op every cycle with random enable gaps
		for (i = 0; i < 64 && !stalled; i++) begin
			if (i % 6 == 0) specialOperand(int'($unsigned($random(seed)) % 7), v);
			else randomOperand(fpCvtPkg::expBias - 4, 135, v);
			applyOperand(($unsigned($random(seed)) % 4) != 0, fpCvtPkg::cvtOpT'(i % 2), v);
		end
		if (!stalled) closeTest();
		if (stalled) begin
			$display("Test failures found");
		end else begin
			allDone = 1'b1;
			k = 0;
			@(posedge clk);
			while (!reportDone && k < 10) begin
				@(posedge clk);
				k++;
			end
			if (!reportDone) begin
				$display("Timeout: checker never printed its closing counts");
				$display("Test failures found");
			end else if (errTotal == 0) begin
				$display("All tests passed!");
			end else begin
				$display("Test failures found");
			end
		end
		$finish;
	end

endmodule

//--- fpCvt.f
design/fpCvtPkg.sv
design/fpClassify.sv
design/fpTrunc.sv
design/fpToInt.sv
design/fpCvtUnit.sv
tests/fpCvtChecker.sv
tests/fpCvtTb.sv
